// File: conv_pkg.sv
//############################################################
// Conversion unit shared definitions
// Operation codes, binary32 layout and integer saturation
//############################################################

package conv_pkg;

        // Direction of one conversion request
        typedef enum logic {
                OP_I2F = 1'b0,
                OP_F2I = 1'b1
        } conv_op_e;

        //############################################################
        // binary32 layout
        //############################################################

        localparam int F32_EXP_W = 8;
        localparam int F32_MAN_W = 23;
        localparam int F32_BIAS = 127;

        // Unbiased exponent with room for sign and the rounding carry
        typedef logic signed [F32_EXP_W+1:0] sexp_t;

        //############################################################
        // Float to integer limits
        //############################################################

        // Returned for values too large, infinities and NaN
        localparam logic [31:0] F2I_SATURATE = 32'h8000_0000;

        // Largest unbiased exponent that still fits a signed 32-bit word
        localparam int F2I_MAX_EXP = 30;

endpackage

// File: int_to_float.sv
//############################################################
// Signed 32-bit integer to binary32 converter
// Serial normalisation, round to nearest with ties to even
//############################################################

module int_to_float (
        input  logic        clk,
        input  logic        rst,
        input  logic        a_stb,
        input  logic [31:0] a_data,
        output logic        a_ack,
        output logic        z_stb,
        output logic [31:0] z_data,
        input  logic        z_ack
);

        typedef enum logic [2:0] {
                S_GET,
                S_SIGN,
                S_LOAD,
                S_NORM,
                S_ROUND,
                S_PACK,
                S_PUT
        } state_e;

        state_e state;

        logic [31:0] a;
        logic [31:0] value;
        logic z_s;
        conv_pkg::sexp_t z_e;
        conv_pkg::sexp_t biased;
        // Mantissa with hidden bit, and the bits below it
        logic [conv_pkg::F32_MAN_W:0] z_m;
        logic [30-conv_pkg::F32_MAN_W:0] z_r;
        logic guard;
        logic round_bit;
        logic sticky;

        assign biased = z_e + conv_pkg::sexp_t'(conv_pkg::F32_BIAS);

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= S_GET;
                        a_ack <= 1'b0;
                        z_stb <= 1'b0;
                end else begin
                        case (state)
                        S_GET: begin
                                a_ack <= 1'b1;
                                if (a_ack && a_stb) begin
                                        a <= a_data;
                                        a_ack <= 1'b0;
                                        state <= S_SIGN;
                                end
                        end
                        S_SIGN: begin
                                z_s <= a[31];
                                if (a == '0) begin
                                        // Zero skips normalisation and packs to all zeros
                                        z_m <= '0;
                                        z_e <= -conv_pkg::sexp_t'(conv_pkg::F32_BIAS);
                                        guard <= 1'b0;
                                        round_bit <= 1'b0;
                                        sticky <= 1'b0;
                                        state <= S_ROUND;
                                end else begin
                                        // Most negative value negates to itself, read as unsigned
                                        value <= a[31] ? -a : a;
                                        state <= S_LOAD;
                                end
                        end
                        S_LOAD: begin
                                z_e <= 31;
                                z_m <= value[31:31-conv_pkg::F32_MAN_W];
                                z_r <= value[30-conv_pkg::F32_MAN_W:0];
                                state <= S_NORM;
                        end
                        S_NORM: begin
                                if (!z_m[conv_pkg::F32_MAN_W]) begin
                                        z_e <= z_e - 1;
                                        z_m <= {z_m[conv_pkg::F32_MAN_W-1:0], z_r[$left(z_r)]};
                                        z_r <= z_r << 1;
                                end else begin
                                        guard <= z_r[$left(z_r)];
                                        round_bit <= z_r[$left(z_r)-1];
                                        sticky <= |z_r[$left(z_r)-2:0];
                                        state <= S_ROUND;
                                end
                        end
                        S_ROUND: begin
                                if (guard && (round_bit || sticky || z_m[0])) begin
                                        z_m <= z_m + 1;
                                        // Mantissa overflow becomes 1.0 at the next exponent
                                        if (&z_m) begin
                                                z_e <= z_e + 1;
                                        end
                                end
                                state <= S_PACK;
                        end
                        S_PACK: begin
                                z_data <= {z_s, biased[conv_pkg::F32_EXP_W-1:0],
                                           z_m[conv_pkg::F32_MAN_W-1:0]};
                                z_stb <= 1'b1;
                                state <= S_PUT;
                        end
                        S_PUT: begin
                                if (z_ack) begin
                                        z_stb <= 1'b0;
                                        state <= S_GET;
                                end
                        end
                        default: begin
                                state <= S_GET;
                        end
                        endcase
                end
        end

        // Normalisation terminates only on a nonzero mantissa
        assert property (@(posedge clk) disable iff (rst)
                state == S_NORM |-> {z_m, z_r} != '0);

        assert property (@(posedge clk) disable iff (rst)
                z_stb && !z_ack |=> $stable(z_data));

endmodule

// File: float_to_int.sv
//############################################################
// binary32 to signed 32-bit integer converter
// Truncates toward zero, saturates out-of-range inputs
//############################################################

module float_to_int (
        input  logic        clk,
        input  logic        rst,
        input  logic        a_stb,
        input  logic [31:0] a_data,
        output logic        a_ack,
        output logic        z_stb,
        output logic [31:0] z_data,
        input  logic        z_ack
);

        typedef enum logic [2:0] {
                S_GET,
                S_UNPACK,
                S_CLASSIFY,
                S_SHIFT,
                S_PACK,
                S_PUT
        } state_e;

        state_e state;

        logic [31:0] a;
        logic a_s;
        conv_pkg::sexp_t e;
        logic [conv_pkg::F32_MAN_W-1:0] a_m;
        logic [31:0] value;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= S_GET;
                        a_ack <= 1'b0;
                        z_stb <= 1'b0;
                end else begin
                        case (state)
                        S_GET: begin
                                a_ack <= 1'b1;
                                if (a_ack && a_stb) begin
                                        a <= a_data;
                                        a_ack <= 1'b0;
                                        state <= S_UNPACK;
                                end
                        end
                        S_UNPACK: begin
                                a_s <= a[31];
                                e <= conv_pkg::sexp_t'(a[30:conv_pkg::F32_MAN_W])
                                     - conv_pkg::sexp_t'(conv_pkg::F32_BIAS);
                                a_m <= a[conv_pkg::F32_MAN_W-1:0];
                                state <= S_CLASSIFY;
                        end
                        S_CLASSIFY: begin
                                if (e < 0) begin
                                        // Magnitude below one, including zero and subnormals
                                        z_data <= '0;
                                        state <= S_PACK;
                                end else if (e > conv_pkg::sexp_t'(conv_pkg::F2I_MAX_EXP)) begin
                                        z_data <= conv_pkg::F2I_SATURATE;
                                        state <= S_PACK;
                                end else begin
                                        // Hidden bit goes to bit 31 and is shifted down to bit e
                                        value <= {1'b1, a_m, {(31-conv_pkg::F32_MAN_W){1'b0}}};
                                        state <= S_SHIFT;
                                end
                        end
                        S_SHIFT: begin
                                if (e != 31) begin
                                        value <= value >> 1;
                                        e <= e + 1;
                                end else begin
                                        z_data <= a_s ? -value : value;
                                        state <= S_PACK;
                                end
                        end
                        S_PACK: begin
                                z_stb <= 1'b1;
                                state <= S_PUT;
                        end
                        S_PUT: begin
                                if (z_ack) begin
                                        z_stb <= 1'b0;
                                        state <= S_GET;
                                end
                        end
                        default: begin
                                state <= S_GET;
                        end
                        endcase
                end
        end

        assert property (@(posedge clk) disable iff (rst)
                z_stb && !z_ack |=> $stable(z_data));

endmodule

// File: conv_dispatch.sv
//############################################################
// Request dispatcher for the conversion unit
// Steers one request to a converter and returns its result
//############################################################

module conv_dispatch (
        input  logic                clk,
        input  logic                rst,
        input  logic                in_stb,
        input  conv_pkg::conv_op_e  in_op,
        input  logic [31:0]         in_data,
        output logic                in_ack,
        output logic                out_stb,
        output logic [31:0]         out_data,
        input  logic                out_ack,
        output logic                i2f_a_stb,
        output logic [31:0]         i2f_a_data,
        input  logic                i2f_a_ack,
        input  logic                i2f_z_stb,
        input  logic [31:0]         i2f_z_data,
        output logic                i2f_z_ack,
        output logic                f2i_a_stb,
        output logic [31:0]         f2i_a_data,
        input  logic                f2i_a_ack,
        input  logic                f2i_z_stb,
        input  logic [31:0]         f2i_z_data,
        output logic                f2i_z_ack
);

        typedef enum logic [1:0] {
                S_GET,
                S_REQ,
                S_RES,
                S_PUT
        } state_e;

        state_e state;
        conv_pkg::conv_op_e op;
        logic [31:0] operand;
        logic sel_i2f;
        logic req_ack;
        logic res_stb;
        logic [31:0] res_data;

        assign sel_i2f = (op == conv_pkg::OP_I2F);

        // Only the selected converter sees a strobe or an acknowledge
        assign i2f_a_stb = (state == S_REQ) && sel_i2f;
        assign f2i_a_stb = (state == S_REQ) && !sel_i2f;
        assign i2f_a_data = operand;
        assign f2i_a_data = operand;
        assign i2f_z_ack = (state == S_RES) && sel_i2f;
        assign f2i_z_ack = (state == S_RES) && !sel_i2f;

        assign req_ack = sel_i2f ? i2f_a_ack : f2i_a_ack;
        assign res_stb = sel_i2f ? i2f_z_stb : f2i_z_stb;
        assign res_data = sel_i2f ? i2f_z_data : f2i_z_data;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= S_GET;
                        in_ack <= 1'b0;
                        out_stb <= 1'b0;
                end else begin
                        case (state)
                        S_GET: begin
                                in_ack <= 1'b1;
                                if (in_ack && in_stb) begin
                                        op <= in_op;
                                        operand <= in_data;
                                        in_ack <= 1'b0;
                                        state <= S_REQ;
                                end
                        end
                        S_REQ: begin
                                if (req_ack) begin
                                        state <= S_RES;
                                end
                        end
                        S_RES: begin
                                if (res_stb) begin
                                        out_data <= res_data;
                                        out_stb <= 1'b1;
                                        state <= S_PUT;
                                end
                        end
                        S_PUT: begin
                                if (out_ack) begin
                                        out_stb <= 1'b0;
                                        state <= S_GET;
                                end
                        end
                        default: begin
                                state <= S_GET;
                        end
                        endcase
                end
        end

        // One request in flight means at most one converter holds a result
        assert property (@(posedge clk) disable iff (rst)
                !(i2f_z_stb && f2i_z_stb));

        assert property (@(posedge clk) disable iff (rst)
                !(in_ack && out_stb));

endmodule

// File: float_convert.sv
//############################################################
// Conversion unit top level
// Dispatcher with integer/float converters in both directions
//############################################################

module float_convert (
        input  logic                clk,
        input  logic                rst,
        input  logic                in_stb,
        input  conv_pkg::conv_op_e  in_op,
        input  logic [31:0]         in_data,
        output logic                in_ack,
        output logic                out_stb,
        output logic [31:0]         out_data,
        input  logic                out_ack
);

        logic        i2f_a_stb;
        logic [31:0] i2f_a_data;
        logic        i2f_a_ack;
        logic        i2f_z_stb;
        logic [31:0] i2f_z_data;
        logic        i2f_z_ack;
        logic        f2i_a_stb;
        logic [31:0] f2i_a_data;
        logic        f2i_a_ack;
        logic        f2i_z_stb;
        logic [31:0] f2i_z_data;
        logic        f2i_z_ack;

        conv_dispatch i_conv_dispatch (
                .clk        (clk),
                .rst        (rst),
                .in_stb     (in_stb),
                .in_op      (in_op),
                .in_data    (in_data),
                .in_ack     (in_ack),
                .out_stb    (out_stb),
                .out_data   (out_data),
                .out_ack    (out_ack),
                .i2f_a_stb  (i2f_a_stb),
                .i2f_a_data (i2f_a_data),
                .i2f_a_ack  (i2f_a_ack),
                .i2f_z_stb  (i2f_z_stb),
                .i2f_z_data (i2f_z_data),
                .i2f_z_ack  (i2f_z_ack),
                .f2i_a_stb  (f2i_a_stb),
                .f2i_a_data (f2i_a_data),
                .f2i_a_ack  (f2i_a_ack),
                .f2i_z_stb  (f2i_z_stb),
                .f2i_z_data (f2i_z_data),
                .f2i_z_ack  (f2i_z_ack)
        );

        int_to_float i_int_to_float (
                .clk    (clk),
                .rst    (rst),
                .a_stb  (i2f_a_stb),
                .a_data (i2f_a_data),
                .a_ack  (i2f_a_ack),
                .z_stb  (i2f_z_stb),
                .z_data (i2f_z_data),
                .z_ack  (i2f_z_ack)
        );

        float_to_int i_float_to_int (
                .clk    (clk),
                .rst    (rst),
                .a_stb  (f2i_a_stb),
                .a_data (f2i_a_data),
                .a_ack  (f2i_a_ack),
                .z_stb  (f2i_z_stb),
                .z_data (f2i_z_data),
                .z_ack  (f2i_z_ack)
        );

endmodule

// File: float_convert_tb.sv
//############################################################
// Testbench for the conversion unit
// Table of requests in both directions under output stalls
//############################################################

module float_convert_tb;

        localparam int NUM_ENTRIES = 18;
        localparam int RESET_CYCLES = 5;

        logic clk;
        logic rst;
        logic in_stb;
        conv_pkg::conv_op_e in_op;
        logic [31:0] in_data;
        logic in_ack;
        logic out_stb;
        logic [31:0] out_data;
        logic out_ack;

        conv_pkg::conv_op_e tab_op [NUM_ENTRIES];
        logic [31:0] tab_in [NUM_ENTRIES];
        logic [31:0] tab_exp [NUM_ENTRIES];
        int n_entries;

        integer seed;
        int pass_count;
        int fail_count;
        int monitor_errors;
        int accepted;
        int results_seen;
        logic rst_prev;
        logic hold_prev;
        logic [31:0] data_prev;

        float_convert i_float_convert (
                .clk      (clk),
                .rst      (rst),
                .in_stb   (in_stb),
                .in_op    (in_op),
                .in_data  (in_data),
                .in_ack   (in_ack),
                .out_stb  (out_stb),
                .out_data (out_data),
                .out_ack  (out_ack)
        );

        always #4 clk = ~clk;

        function automatic logic [31:0] make_float(input logic s, input int exp_biased,
                                                   input logic [conv_pkg::F32_MAN_W-1:0] man);
                logic [conv_pkg::F32_EXP_W-1:0] e;
                e = exp_biased[conv_pkg::F32_EXP_W-1:0];
                return {s, e, man};
        endfunction

        task automatic add_entry(input conv_pkg::conv_op_e op, input logic [31:0] din,
                                 input logic [31:0] dexp);
                tab_op[n_entries] = op;
                tab_in[n_entries] = din;
                tab_exp[n_entries] = dexp;
                n_entries++;
        endtask

        //############################################################
        // Stimulus table with directions alternating entry by entry
        //############################################################

        task automatic fill_table();
                int inf_exp;
                int big_exp;
                inf_exp = (1 << conv_pkg::F32_EXP_W) - 1;
                big_exp = conv_pkg::F32_BIAS + conv_pkg::F2I_MAX_EXP + 1;
                n_entries = 0;
                add_entry(conv_pkg::OP_I2F, 32'd0, 32'h0000_0000);
                add_entry(conv_pkg::OP_F2I, 32'h4049_0FDB, 32'd3);
                add_entry(conv_pkg::OP_I2F, 32'd1, make_float(1'b0, conv_pkg::F32_BIAS, '0));
                add_entry(conv_pkg::OP_F2I, 32'hC049_0FDB, 32'hFFFF_FFFD);
                add_entry(conv_pkg::OP_I2F, 32'hFFFF_FFFF, make_float(1'b1, conv_pkg::F32_BIAS, '0));
                add_entry(conv_pkg::OP_F2I, 32'h4EFF_FFFF, 32'd2147483520);
                add_entry(conv_pkg::OP_I2F, 32'h7FFF_FFFF, make_float(1'b0, big_exp, '0));
                add_entry(conv_pkg::OP_F2I, make_float(1'b0, conv_pkg::F32_BIAS - 1, '0), 32'd0);
                add_entry(conv_pkg::OP_I2F, 32'h8000_0000, make_float(1'b1, big_exp, '0));
                // Smallest subnormal
                add_entry(conv_pkg::OP_F2I, make_float(1'b0, 0, 23'd1), 32'd0);
                add_entry(conv_pkg::OP_I2F, 32'd16777217, 32'h4B80_0000);
                add_entry(conv_pkg::OP_F2I, make_float(1'b1, 0, '0), 32'd0);
                add_entry(conv_pkg::OP_I2F, 32'd16777219, 32'h4B80_0002);
                add_entry(conv_pkg::OP_F2I, make_float(1'b0, big_exp, '0), conv_pkg::F2I_SATURATE);
                add_entry(conv_pkg::OP_I2F, 32'd16777221, 32'h4B80_0002);
                add_entry(conv_pkg::OP_F2I, make_float(1'b0, inf_exp, '0), conv_pkg::F2I_SATURATE);
                add_entry(conv_pkg::OP_I2F, 32'd33554435, 32'h4C00_0001);
                add_entry(conv_pkg::OP_F2I, make_float(1'b0, inf_exp, 23'h40_0000),
                          conv_pkg::F2I_SATURATE);
        endtask

        // Send one request, stall the result for a random time, then take it
        task automatic run_entry(input int idx);
                int stall;
                logic [31:0] got;
                logic ok;
                stall = $unsigned($random(seed)) % 8;
                @(posedge clk);
                #1;
                in_stb = 1'b1;
                in_op = tab_op[idx];
                in_data = tab_in[idx];
                do @(posedge clk); while (!in_ack);
                #1;
                in_stb = 1'b0;
                do @(posedge clk); while (!out_stb);
                repeat (stall) @(posedge clk);
                #1;
                out_ack = 1'b1;
                do @(posedge clk); while (!out_stb);
                got = out_data;
                #1;
                out_ack = 1'b0;
                ok = (got == tab_exp[idx]);
                assert (ok) else begin
                        $display("Fail out_data entry %0d: expected %h, got %h",
                                 idx, tab_exp[idx], got);
                end
                if (ok) begin
                        pass_count++;
                end else begin
                        fail_count++;
                end
                $display("entry %0d %s in %h out %h stall %0d %s", idx,
                         (tab_op[idx] == conv_pkg::OP_I2F) ? "i2f" : "f2i",
                         tab_in[idx], got, stall, ok ? "ok" : "wrong");
        endtask

        //############################################################
        // Handshake monitor
        //############################################################

        always @(posedge clk) begin
                if (rst_prev) begin
                        assert (!in_ack && !out_stb) else begin
                                $display("Strobe or acknowledge was high ",
                                         "in the cycle after reset");
                                monitor_errors++;
                        end
                end
                if (!rst) begin
                        assert (!(in_ack && out_stb)) else begin
                                $display("in_ack was high while out_stb was high");
                                monitor_errors++;
                        end
                        // Every result offered must answer an accepted request
                        if (accepted == results_seen) begin
                                assert (!out_stb) else begin
                                        $display("A result appeared with no request waiting");
                                        monitor_errors++;
                                end
                        end
                        if (hold_prev) begin
                                assert (out_data == data_prev) else begin
                                        $display("Fail out_data held: %h changed to %h",
                                                 data_prev, out_data);
                                        monitor_errors++;
                                end
                        end
                        if (in_stb && in_ack) begin
                                accepted <= accepted + 1;
                        end
                        if (out_stb && out_ack) begin
                                results_seen <= results_seen + 1;
                        end
                end
                rst_prev <= rst;
                hold_prev <= out_stb && !out_ack;
                data_prev <= out_data;
        end

        initial begin
                repeat (NUM_ENTRIES * 60 + RESET_CYCLES) @(posedge clk);
                $display("Watchdog expired while waiting on a DUT handshake");
                $display("TEST FAILED");
                $finish;
        end

        initial begin
                clk = 1'b0;
                rst = 1'b1;
                in_stb = 1'b0;
                in_op = conv_pkg::OP_I2F;
                in_data = '0;
                out_ack = 1'b0;
                seed = 32'h6044;
                pass_count = 0;
                fail_count = 0;
                monitor_errors = 0;
                accepted = 0;
                results_seen = 0;
                rst_prev = 1'b0;
                hold_prev = 1'b0;
                data_prev = '0;
                fill_table();
                repeat (RESET_CYCLES) @(posedge clk);
                #1;
                rst = 1'b0;
                for (int i = 0; i < n_entries; i++) begin
                        run_entry(i);
                end
                repeat (4) @(posedge clk);
                $display("Summary: %0d entries passed, %0d failed, %0d handshake errors",
                         pass_count, fail_count, monitor_errors);
                if (fail_count == 0 && monitor_errors == 0) begin
                        $display("TEST PASSED");
                end else begin
                        $display("TEST FAILED");
                end
                $finish;
        end

endmodule

// File: vlog.f
conv_pkg.sv
int_to_float.sv
float_to_int.sv
conv_dispatch.sv
float_convert.sv
float_convert_tb.sv

// File: Makefile
TOP = float_convert_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
